//--- rtl/busReadPort.sv
// bus read port: output enable priority decode and registered read byte.
`default_nettype none

module busReadPort (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    oePad1N,
    input  logic                    oePad2N,
    input  logic                    oeRandomN,
    input  gamepadPkg::padButtons_u pad1State,
    input  gamepadPkg::padButtons_u pad2State,
    input  logic [7:0]              randomValue,
    output logic                    readingPad,
    output logic                    randomAdvance,
    output logic [7:0]              q,
    output logic                    qValid
);

    import gamepadPkg::*;

    readSource_e source;
    logic [7:0]  selected;

    // ------------------------------------------------------------------------
    // source decode
    // ------------------------------------------------------------------------
    // pad1 over pad2 over random.
    always_comb
    begin
        if (!oePad1N)
            source = SRC_PAD1;
        else if (!oePad2N)
            source = SRC_PAD2;
        else if (!oeRandomN)
            source = SRC_RANDOM;
        else
            source = SRC_NONE;
    end

    always_comb
    begin
        case (source)
            SRC_PAD1:   selected = pad1State.raw;
            SRC_PAD2:   selected = pad2State.raw;
            SRC_RANDOM: selected = randomValue;
            default:    selected = 8'd0;
        endcase
    end

    assign readingPad    = (source == SRC_PAD1) || (source == SRC_PAD2);
    assign randomAdvance = (source == SRC_RANDOM);  // lfsr steps on the same edge.

    // one cycle latency, q holds between reads.
    always_ff @(posedge clk)
    begin
        if (rst)
            qValid <= 1'b0;
        else
            qValid <= (source != SRC_NONE);
    end

    always_ff @(posedge clk)
    begin
        if (source != SRC_NONE)
            q <= selected;
    end

endmodule

`default_nettype wire

//--- rtl/gamepadAdapter.sv
// gamepad adapter top: pad reader, state store, random source and bus read port.
`default_nettype none

module gamepadAdapter #(
    parameter int         POLL_CYCLES     = 64,
    parameter int         HALF_BIT_CYCLES = 2,
    parameter logic [7:0] SEED_DEFAULT    = 8'd29
) (
    input  logic       clk,
    input  logic       rst,
    output logic       padLatch,
    output logic       padClk,
    input  logic       pad1Data,
    input  logic       pad2Data,
    input  logic       oePad1N,
    input  logic       oePad2N,
    input  logic       oeRandomN,
    output logic [7:0] q,
    output logic       qValid,
    input  logic       seedValid,
    input  logic [7:0] seed
);

    import gamepadPkg::*;

    padButtons_u pad1State;
    padButtons_u pad2State;
    logic [7:0]  randomValue;
    logic        readingPad;
    logic        randomAdvance;

    padReportIf report ();

    // ------------------------------------------------------------------------
    // pad side
    // ------------------------------------------------------------------------
    nesPadReader #(
        .POLL_CYCLES     (POLL_CYCLES),
        .HALF_BIT_CYCLES (HALF_BIT_CYCLES)
    ) u_nesPadReader (
        .clk      (clk),
        .rst      (rst),
        .padLatch (padLatch),
        .padClk   (padClk),
        .pad1Data (pad1Data),
        .pad2Data (pad2Data),
        .report   (report.source)
    );

    padStateStore u_padStateStore (
        .clk        (clk),
        .rst        (rst),
        .report     (report.sink),
        .readingPad (readingPad),
        .pad1State  (pad1State),
        .pad2State  (pad2State)
    );

    // ------------------------------------------------------------------------
    // bus side
    // ------------------------------------------------------------------------
    randomSource #(
        .SEED_DEFAULT (SEED_DEFAULT)
    ) u_randomSource (
        .clk       (clk),
        .rst       (rst),
        .advance   (randomAdvance),
        .seedValid (seedValid),
        .seed      (seed),
        .value     (randomValue)
    );

    busReadPort u_busReadPort (
        .clk           (clk),
        .rst           (rst),
        .oePad1N       (oePad1N),
        .oePad2N       (oePad2N),
        .oeRandomN     (oeRandomN),
        .pad1State     (pad1State),
        .pad2State     (pad2State),
        .randomValue   (randomValue),
        .readingPad    (readingPad),
        .randomAdvance (randomAdvance),
        .q             (q),
        .qValid        (qValid)
    );

endmodule

`default_nettype wire

//--- rtl/gamepadPkg.sv
// gamepad package: report width, button word union, pad id and read source enums.
`default_nettype none

package gamepadPkg;

    localparam int BUTTON_COUNT = 8;  // bits in one nes report.

    // one button word, seen as the raw byte or as named buttons.
    // a sits in bit 0 since the pad shifts it out first.
    typedef union packed {
        logic [BUTTON_COUNT-1:0] raw;
        struct packed {
            logic right;
            logic left;
            logic down;
            logic up;
            logic start;
            logic select;
            logic b;
            logic a;
        } button;
    } padButtons_u;

    typedef enum logic {
        PAD1,
        PAD2
    } padId_e;

    // bus read source, after enable priority.
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_PAD1,
        SRC_PAD2,
        SRC_RANDOM
    } readSource_e;

endpackage

`default_nettype wire

//--- rtl/nesPadReader.sv
// nes pad reader: poll timer, latch and clock pulse generation, dual shift capture, send stage.
`default_nettype none

module nesPadReader #(
    parameter int POLL_CYCLES     = 64,
    parameter int HALF_BIT_CYCLES = 2
) (
    input  logic       clk,
    input  logic       rst,
    output logic       padLatch,
    output logic       padClk,
    input  logic       pad1Data,
    input  logic       pad2Data,
    padReportIf.source report
);

    import gamepadPkg::*;

    localparam int HALF_W = (HALF_BIT_CYCLES > 1) ? $clog2(HALF_BIT_CYCLES) : 1;
    localparam int POLL_W = (POLL_CYCLES > 1) ? $clog2(POLL_CYCLES) : 1;
    localparam int IDX_W  = $clog2(2 * BUTTON_COUNT);

    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(HALF_BIT_CYCLES - 1);
    localparam logic [POLL_W-1:0] POLL_LAST = POLL_W'(POLL_CYCLES - 1);
    localparam logic [IDX_W-1:0]  IDX_LAST  = IDX_W'(2 * BUTTON_COUNT - 1);

    logic [POLL_W-1:0]       pollTimer;
    logic                    polling;
    logic [HALF_W-1:0]       halfCnt;   // cycles inside one half period.
    logic [IDX_W-1:0]        halfIdx;   // half period number within the poll.
    logic [BUTTON_COUNT-1:0] pad1Shift;
    logic [BUTTON_COUNT-1:0] pad2Shift;
    logic [1:0]              pending;   // bit 0 pad1, bit 1 pad2.
    logic                    endOfHalf;
    logic                    sampleNow;
    logic                    pollDone;
    logic                    startPoll;
    logic                    reportFire;

    // ------------------------------------------------------------------------
    // poll sequencing
    // ------------------------------------------------------------------------
    // half periods 0 and 1 hold the latch, then even ones carry a clock pulse.
    // a bit is taken at latch fall and at each clock fall.
    always_comb
    begin
        endOfHalf  = polling && (halfCnt == HALF_LAST);
        sampleNow  = endOfHalf && ((halfIdx == IDX_W'(1)) || (halfIdx != '0 && !halfIdx[0]));
        pollDone   = endOfHalf && (halfIdx == IDX_LAST);
        startPoll  = !polling && (pending == 2'b00) && (pollTimer == POLL_LAST);
        reportFire = report.valid && report.ready;
    end

    // saturates while busy, so a stalled send stretches the period.
    always_ff @(posedge clk)
    begin
        if (rst)
            pollTimer <= '0;
        else if (startPoll)
            pollTimer <= '0;
        else if (pollTimer != POLL_LAST)
            pollTimer <= pollTimer + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            polling  <= 1'b0;
            halfCnt  <= '0;
            halfIdx  <= '0;
            padLatch <= 1'b0;
            padClk   <= 1'b0;
        end
        else if (startPoll)
        begin
            polling  <= 1'b1;
            halfCnt  <= '0;
            halfIdx  <= '0;
            padLatch <= 1'b1;
        end
        else if (endOfHalf)
        begin
            halfCnt  <= '0;
            halfIdx  <= halfIdx + 1'b1;
            padLatch <= (halfIdx == '0);         // still high for half 1.
            padClk   <= halfIdx[0] && !pollDone; // rises into even halves.
            if (pollDone)
                polling <= 1'b0;
        end
        else if (polling)
            halfCnt <= halfCnt + 1'b1;
    end

    // pad lines are active low, first bit ends up in bit 0.
    always_ff @(posedge clk)
    begin
        if (sampleNow)
        begin
            pad1Shift <= {~pad1Data, pad1Shift[BUTTON_COUNT-1:1]};
            pad2Shift <= {~pad2Data, pad2Shift[BUTTON_COUNT-1:1]};
        end
    end

    // ------------------------------------------------------------------------
    // send stage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
            pending <= 2'b00;
        else if (pollDone)
            pending <= 2'b11;
        else if (reportFire)
            pending <= pending[0] ? 2'b10 : 2'b00;  // pad1 goes first.
    end

    assign report.valid       = (pending != 2'b00);
    assign report.pad         = pending[0] ? PAD1 : PAD2;
    assign report.buttons.raw = pending[0] ? pad1Shift : pad2Shift;

endmodule

`default_nettype wire

//--- rtl/padReportIf.sv
// pad report interface: valid/ready handshake with pad id and button word.
`default_nettype none

interface padReportIf;

    import gamepadPkg::*;

    logic        valid;
    logic        ready;
    padId_e      pad;      // which pad this report belongs to.
    padButtons_u buttons;  // pressed = 1.

    // reader side.
    modport source (output valid, output pad, output buttons, input ready);

    // store side.
    modport sink (input valid, input pad, input buttons, output ready);

endinterface

`default_nettype wire

//--- rtl/padStateStore.sv
// pad state store: d-pad filter and latest button state per pad.
`default_nettype none

module padStateStore (
    input  logic                    clk,
    input  logic                    rst,
    padReportIf.sink                report,
    input  logic                    readingPad,
    output gamepadPkg::padButtons_u pad1State,
    output gamepadPkg::padButtons_u pad2State
);

    import gamepadPkg::*;

    padButtons_u filtered;
    logic        accept;

    // hold off updates while a bus read samples a pad.
    assign report.ready = !readingPad;
    assign accept       = report.valid && report.ready;

    // ------------------------------------------------------------------------
    // d-pad filter
    // ------------------------------------------------------------------------
    // opposite directions at once cannot happen on a real pad.
    always_comb
    begin
        filtered = report.buttons;
        if (filtered.button.up && filtered.button.down)
        begin
            filtered.button.up   = 1'b0;
            filtered.button.down = 1'b0;
        end
        if (filtered.button.left && filtered.button.right)
        begin
            filtered.button.left  = 1'b0;
            filtered.button.right = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pad1State <= '0;
            pad2State <= '0;
        end
        else if (accept)
        begin
            if (report.pad == PAD1)
                pad1State <= filtered;
            else
                pad2State <= filtered;  // visible to reads next cycle.
        end
    end

endmodule

`default_nettype wire

//--- rtl/randomSource.sv
// random source: seedable 8-bit fibonacci lfsr, taps 8 6 5 4.
`default_nettype none

module randomSource #(
    parameter logic [7:0] SEED_DEFAULT = 8'd29
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       advance,
    input  logic       seedValid,
    input  logic [7:0] seed,
    output logic [7:0] value
);

    logic       feedback;
    logic       seedOk;
    logic [7:0] nextValue;

    // taps counted from 1, so tap 8 is bit 7.
    assign feedback  = value[7] ^ value[5] ^ value[4] ^ value[3];
    assign nextValue = {value[6:0], feedback};

    // an all-zero state would lock up.
    assign seedOk = seedValid && (seed != 8'd0);

    always_ff @(posedge clk)
    begin
        if (rst)
            value <= SEED_DEFAULT;
        else if (seedOk)
            value <= seed;       // seed load wins over a read.
        else if (advance)
            value <= nextValue;  // one step per random read.
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the gamepad adapter testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary -f vlog.f --top-module gamepadAdapterTb --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^Simulation PASSED$'; then
    exit 0
else
    exit 1
fi

//--- sim/gamepadAdapterTb.sv
// testbench: nes pad shift models, file-driven reads and seeds, pad line monitor, compare tasks, timeout.
`default_nettype none

// behavioral nes pad, parallel load on latch, shift on clock rise.
module nesPadModel (
    input  logic       latch,
    input  logic       clock,
    input  logic [7:0] buttons,
    output logic       data
);

    logic [7:0] shiftReg = '0;

    always @(posedge clock or posedge latch)
    begin
        if (latch)
            shiftReg <= buttons;
        else
            shiftReg <= {1'b0, shiftReg[7:1]};  // released after eight bits.
    end

    assign data = ~shiftReg[0];  // active low line.

endmodule

module gamepadAdapterTb;

    import gamepadPkg::*;

    localparam int         POLL_CYCLES     = 64;
    localparam int         HALF_BIT_CYCLES = 2;
    localparam logic [7:0] SEED_DEFAULT    = 8'd29;
    localparam int         RECORD_COUNT    = 27;
    localparam int         FIELD_COUNT     = 6;
    localparam int         CYCLE_LIMIT     = RECORD_COUNT * 3 * POLL_CYCLES + 200;

    localparam logic [7:0] CMD_SET_PADS = 8'h00;
    localparam logic [7:0] CMD_READ     = 8'h01;
    localparam logic [7:0] CMD_SEED     = 8'h02;

    logic       clk;
    logic       rst;
    logic       padLatch;
    logic       padClk;
    logic       pad1Data;
    logic       pad2Data;
    logic       oePad1N;
    logic       oePad2N;
    logic       oeRandomN;
    logic [7:0] q;
    logic       qValid;
    logic       seedValid;
    logic [7:0] seed;
    logic [7:0] pad1Byte;
    logic [7:0] pad2Byte;

    logic [7:0] records [0:RECORD_COUNT*FIELD_COUNT-1];
    logic [7:0] randomModel;  // expected lfsr state.
    int         valueErrors;
    int         otherErrors;
    int         cycleCount;

    int         latchHigh;   // cycles with padLatch high in this poll.
    int         clkHigh;     // cycles with padClk high in this pulse.
    int         clkPulses;   // padClk pulses in this poll.
    int         pollCount;
    int         sinceReset;  // clock edges since reset release.
    logic       lastLatch;
    logic       lastClk;

    gamepadAdapter #(
        .POLL_CYCLES     (POLL_CYCLES),
        .HALF_BIT_CYCLES (HALF_BIT_CYCLES),
        .SEED_DEFAULT    (SEED_DEFAULT)
    ) u_gamepadAdapter (
        .clk       (clk),
        .rst       (rst),
        .padLatch  (padLatch),
        .padClk    (padClk),
        .pad1Data  (pad1Data),
        .pad2Data  (pad2Data),
        .oePad1N   (oePad1N),
        .oePad2N   (oePad2N),
        .oeRandomN (oeRandomN),
        .q         (q),
        .qValid    (qValid),
        .seedValid (seedValid),
        .seed      (seed)
    );

    nesPadModel u_pad1Model (
        .latch   (padLatch),
        .clock   (padClk),
        .buttons (pad1Byte),
        .data    (pad1Data)
    );

    nesPadModel u_pad2Model (
        .latch   (padLatch),
        .clock   (padClk),
        .buttons (pad2Byte),
        .data    (pad2Data)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // reference rules
    // ------------------------------------------------------------------------
    // taps 8 6 5 4, one new bit per step.
    function automatic logic [7:0] lfsrStep(input logic [7:0] state);
        logic feedback;
        feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
        return {state[6:0], feedback};
    endfunction

    // enable mask bit 0 pad1, bit 1 pad2, bit 2 random.
    function automatic readSource_e expectedSource(input logic [2:0] mask);
        if (mask[0])
            return SRC_PAD1;
        else if (mask[1])
            return SRC_PAD2;
        else if (mask[2])
            return SRC_RANDOM;
        return SRC_NONE;
    endfunction

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic checkPad(input string name, input padButtons_u got,
                            input padButtons_u expected);
        if (got !== expected)
        begin
            $display("error at %0t: %s got %02h expected %02h",
                     $time, name, got.raw, expected.raw);
            valueErrors++;
        end
    endtask

    task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] expected);
        if (got !== expected)
        begin
            $display("error at %0t: %s got %02h expected %02h", $time, name, got, expected);
            valueErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, expected);
            valueErrors++;
        end
    endtask

    task automatic checkCount(input string name, input int got, input int expected);
        if (got != expected)
        begin
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, expected);
            valueErrors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // pad line monitor
    // ------------------------------------------------------------------------
    // lines are seen at the edge, one cycle behind the flops driving them.
    always @(posedge clk)
    begin
        if (rst)
        begin
            pollCount  = 0;
            sinceReset = 0;
        end
        else
        begin
            sinceReset++;
            if (sinceReset == 1)
            begin
                checkFlag("padLatch", padLatch, 1'b0);
                checkFlag("padClk", padClk, 1'b0);
            end
            if (padLatch && !lastLatch)
            begin
                if (pollCount == 0)
                    checkCount("padLatch first rise", sinceReset, POLL_CYCLES + 1);
                else
                    checkCount("padClk pulses", clkPulses, BUTTON_COUNT - 1);
                pollCount++;
                latchHigh = 0;
                clkPulses = 0;
            end
            if (!padLatch && lastLatch)
                checkCount("padLatch high cycles", latchHigh, 2 * HALF_BIT_CYCLES);
            if (padClk && !lastClk)
            begin
                clkPulses++;
                clkHigh = 0;
            end
            if (!padClk && lastClk)
                checkCount("padClk high cycles", clkHigh, HALF_BIT_CYCLES);
            if (padLatch)
                latchHigh++;
            if (padClk)
                clkHigh++;
        end
        lastLatch = padLatch;
        lastClk   = padClk;
    end

    // ------------------------------------------------------------------------
    // stimulus tasks
    // ------------------------------------------------------------------------
    // two poll periods, so one full poll sees the new bytes.
    task automatic setPads(input logic [7:0] newPad1, input logic [7:0] newPad2);
        @(posedge clk);
        #10;
        pad1Byte = newPad1;
        pad2Byte = newPad2;
        repeat (2 * POLL_CYCLES) @(posedge clk);
    endtask

    task automatic loadSeed(input logic [7:0] newSeed);
        @(posedge clk);
        #10;
        seedValid = 1'b1;
        seed      = newSeed;
        @(posedge clk);
        #10;
        seedValid = 1'b0;
        seed      = 8'd0;
        if (newSeed != 8'd0)
            randomModel = newSeed;  // zero seed leaves the lfsr alone.
    endtask

    task automatic busRead(input int index, input logic [2:0] mask, input logic [7:0] expected);
        readSource_e src;
        padButtons_u gotWord;
        padButtons_u expectedWord;
        src = expectedSource(mask);
        @(posedge clk);
        #10;
        oePad1N   = !mask[0];
        oePad2N   = !mask[1];
        oeRandomN = !mask[2];
        @(posedge clk);
        #10;
        oePad1N   = 1'b1;
        oePad2N   = 1'b1;
        oeRandomN = 1'b1;
        if (src == SRC_NONE)
            checkFlag("qValid", qValid, 1'b0);
        else
        begin
            if (qValid !== 1'b1)
            begin
                $display("qValid missing at %0t after a read of %s", $time, src.name());
                otherErrors++;
            end
            if (src == SRC_RANDOM)
            begin
                if (expected !== randomModel)
                begin
                    $display("record %0d of the data file expects %02h",
                             index, expected);
                    $display("but the lfsr model gives %02h", randomModel);
                    otherErrors++;
                end
                checkByte("q", q, randomModel);
                randomModel = lfsrStep(randomModel);  // steps only when random wins.
            end
            else
            begin
                gotWord.raw      = q;
                expectedWord.raw = expected;
                checkPad("q", gotWord, expectedWord);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial
    begin
        int         base;
        logic [7:0] command;
        valueErrors = 0;
        otherErrors = 0;
        rst         = 1'b1;
        oePad1N     = 1'b1;
        oePad2N     = 1'b1;
        oeRandomN   = 1'b1;
        seedValid   = 1'b0;
        seed        = 8'd0;
        pad1Byte    = 8'd0;
        pad2Byte    = 8'd0;
        randomModel = SEED_DEFAULT;
        $readmemh("sim/gamepadInput.hex", records);
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        for (int i = 0; i < RECORD_COUNT; i++)
        begin
            base    = i * FIELD_COUNT;
            command = records[base];
            case (command)
                CMD_SET_PADS: setPads(records[base + 1], records[base + 2]);
                CMD_READ:     busRead(i, records[base + 3][2:0], records[base + 5]);
                CMD_SEED:     loadSeed(records[base + 4]);
                default:
                begin
                    $display("record %0d holds an unknown command %02h", i, command);
                    otherErrors++;
                end
            endcase
        end
        $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // run limit from the record count.
    initial
    begin
        cycleCount = 0;
        while (cycleCount < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/gamepadInput.hex
// cmd (00 set pads, 01 read, 02 seed)  pad1  pad2  enables low (bit0 pad1, bit1 pad2, bit2 random)
// seed  expected byte
01 00 00 00 00 00
01 00 00 01 00 00
01 00 00 02 00 00
01 00 00 04 00 1D
01 00 00 04 00 3A
01 00 00 04 00 75
02 00 00 00 00 00
01 00 00 04 00 EA
02 00 00 00 3C 00
01 00 00 04 00 3C
01 00 00 04 00 79
00 81 42 00 00 00
01 00 00 01 00 81
01 00 00 02 00 42
00 31 C4 00 00 00
01 00 00 01 00 01
01 00 00 02 00 04
00 F8 5A 00 00 00
01 00 00 01 00 08
01 00 00 02 00 5A
01 00 00 07 00 08
01 00 00 06 00 5A
01 00 00 05 00 08
01 00 00 04 00 F3
01 00 00 03 00 08
01 00 00 04 00 E7
01 00 00 00 00 00

//--- vlog.f
rtl/gamepadPkg.sv
rtl/padReportIf.sv
rtl/nesPadReader.sv
rtl/padStateStore.sv
rtl/randomSource.sv
rtl/busReadPort.sv
rtl/gamepadAdapter.sv
sim/gamepadAdapterTb.sv
